// ==== all.f ====
hdl/raster_geom_pkg.sv
hdl/iter_ctrl_pkg.sv
hdl/sample_step_config.sv
hdl/bbox_sample_iterator.sv
hdl/sample_test_iterator.sv
testbench/tb_clock_gen.sv
testbench/sample_iterator_props.sv
testbench/tb_sample_test_iterator.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_sample_test_iterator -f all.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qx "TEST PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== testbench/tb_sample_test_iterator.sv ====
// RADIX here must match the DUT and boxes stay within a few dozen pixels so nothing wraps
`timescale 1ns/100ps

module tb_sample_test_iterator;
    import raster_geom_pkg::*;
    import iter_ctrl_pkg::*;

    localparam int unsigned RADIX = 10;
    // 4 aligned, 4 unaligned, 1 zero-size, 12 back to back
    localparam int NUM_BOXES = 21;
    localparam int TIMEOUT_CYCLES = 40 * NUM_BOXES + 50;

    logic       clk;
    logic       rst;
    coord_t     tri_in [VERTS-1:0][AXIS-1:0];
    color_t     color_in [COLORS-1:0];
    coord_t     box_in [1:0][1:0];
    logic       tri_valid;
    msaa_code_t msaa_code;
    coord_t     tri_out [VERTS-1:0][AXIS-1:0];
    color_t     color_out [COLORS-1:0];
    coord_t     sample [1:0];
    logic       sample_valid;
    logic       halt_n;

    integer seed;
    int     errors;
    int     checks;
    int     boxes;
    int     cycles;

    // Expected samples in scan order, payload held since acceptance
    coord_t exp_x [$];
    coord_t exp_y [$];
    coord_t exp_tri [VERTS-1:0][AXIS-1:0];
    color_t exp_color [COLORS-1:0];

    msaa_code_t codes [4] = '{4'b1000, 4'b0100, 4'b0010, 4'b0001};

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(2)) u_clk (.clk(clk), .rst(rst));

    sample_test_iterator #(.RADIX(RADIX)) uut (
        .clk(clk), .rst(rst), .tri_in(tri_in), .color_in(color_in), .box_in(box_in),
        .tri_valid(tri_valid), .msaa_code(msaa_code), .tri_out(tri_out),
        .color_out(color_out), .sample(sample), .sample_valid(sample_valid), .halt_n(halt_n)
    );

    bind bbox_sample_iterator sample_iterator_props u_props (
        .clk(clk), .rst(rst), .state(state), .tri_valid(tri_valid), .at_end_box(at_end_box),
        .sample_valid(sample_valid), .sample(sample), .box(box)
    );

    task automatic check_coord(string name, coord_t expected, coord_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_color(string name, color_t expected, color_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected %b actual %b at %0t", name, expected, actual, $time);
        end
    endtask

    function automatic int rand_range(int lo, int hi);
        int r;
        r = $random(seed);
        return lo + (r & 32'h7fffffff) % (hi - lo + 1);
    endfunction

    // Sample spacing per MSAA code, one pixel is 1 << RADIX
    // 1x walks whole pixels, 4x half, 16x a quarter, 64x an eighth
    function automatic int step_for_code(msaa_code_t code);
        case (code)
            4'b1000: return 1 << RADIX;
            4'b0100: return 1 << (RADIX - 1);
            4'b0010: return 1 << (RADIX - 2);
            4'b0001: return 1 << (RADIX - 3);
            default: return 0;
        endcase
    endfunction

    // Positions on one axis, ceil(d/step)+1 or a single one for an empty range
    function automatic int axis_positions(int d, int s);
        if (d <= 0) begin
            return 1;
        end
        return (d + s - 1) / s + 1;
    endfunction

    // Rows bottom to top, each row left to right
    function automatic void ref_scan(coord_t lo_x, coord_t lo_y, coord_t hi_x, coord_t hi_y,
                                     step_t st);
        int s;
        int nx;
        int ny;
        s  = int'(st);
        nx = axis_positions(int'(hi_x) - int'(lo_x), s);
        ny = axis_positions(int'(hi_y) - int'(lo_y), s);
        for (int iy = 0; iy < ny; iy++) begin
            for (int ix = 0; ix < nx; ix++) begin
                exp_x.push_back(coord_t'(int'(lo_x) + ix * s));
                exp_y.push_back(coord_t'(int'(lo_y) + iy * s));
            end
        end
    endfunction

    // Upper corner n-1 steps away, pulled in by part of a step when unaligned
    function automatic coord_t box_hi(coord_t lo, int n, int s, bit aligned);
        int off;
        off = aligned ? 0 : rand_range(1, s - 1);
        return coord_t'(int'(lo) + (n - 1) * s - off);
    endfunction

    task automatic randomize_payload();
        foreach (tri_in[v, a]) tri_in[v][a] = coord_t'($random(seed));
        foreach (color_in[c]) color_in[c] = color_t'($random(seed));
    endtask

    // One box from presentation to the waiting state
    task automatic run_box(msaa_code_t code, int nx, int ny, bit aligned, bit churn,
                           bit keep_valid);
        int     s;
        coord_t lo_x;
        coord_t lo_y;
        coord_t hi_x;
        coord_t hi_y;
        coord_t held_tri [VERTS-1:0][AXIS-1:0];
        color_t held_color [COLORS-1:0];
        // Expected spacing for this code
        s = step_for_code(code);
        while (halt_n !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        randomize_payload();
        lo_x = coord_t'($random(seed) % (1 << (RADIX + 5)));
        lo_y = coord_t'($random(seed) % (1 << (RADIX + 5)));
        hi_x = box_hi(lo_x, nx, s, aligned);
        hi_y = box_hi(lo_y, ny, s, aligned);
        box_in[0][0] = lo_x;
        box_in[0][1] = lo_y;
        box_in[1][0] = hi_x;
        box_in[1][1] = hi_y;
        msaa_code  = code;
        tri_valid  = 1'b1;
        held_tri   = tri_in;
        held_color = color_in;
        @(posedge clk);
        #1;
        // Accepted on the first waiting edge
        check_flag("accept_valid", 1'b1, sample_valid);
        exp_tri   = held_tri;
        exp_color = held_color;
        ref_scan(lo_x, lo_y, hi_x, hi_y, step_t'(s));
        boxes++;
        if (!keep_valid) begin
            tri_valid = 1'b0;
        end
        while (halt_n === 1'b0) begin
            if (churn) begin
                // Payload and code move while the walk must ignore them
                randomize_payload();
                msaa_code = {msaa_code[0], msaa_code[3:1]};
            end
            @(posedge clk);
            #1;
        end
        if (!keep_valid) begin
            repeat (2) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // Compare on the falling edge, half a period away from every change
    always @(negedge clk) begin
        if (!rst) begin
            check_flag("halt_n_vs_valid", !sample_valid, halt_n);
            if (sample_valid) begin
                if (exp_x.size() == 0) begin
                    errors++;
                    $display("Extra sample (%h, %h) arrived with none expected at %0t",
                             sample[0], sample[1], $time);
                end else begin
                    check_coord("sample_x", exp_x.pop_front(), sample[0]);
                    check_coord("sample_y", exp_y.pop_front(), sample[1]);
                end
                foreach (tri_out[v, a]) check_coord("tri_out", exp_tri[v][a], tri_out[v][a]);
                foreach (color_out[c]) check_color("color_out", exp_color[c], color_out[c]);
            end else if (exp_x.size() != 0) begin
                errors++;
                $display("Box ended with %0d samples missing at %0t", exp_x.size(), $time);
                exp_x.delete();
                exp_y.delete();
            end
        end
    end

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed      = 32'h526d;
        errors    = 0;
        checks    = 0;
        boxes     = 0;
        tri_valid = 1'b0;
        msaa_code = 4'b1000;
        tri_in    = '{default: '0};
        color_in  = '{default: '0};
        box_in    = '{default: '0};
        @(negedge rst);
        // Idle after reset
        repeat (4) begin
            check_flag("reset_valid", 1'b0, sample_valid);
            check_flag("reset_halt_n", 1'b1, halt_n);
            @(posedge clk);
            #1;
        end
        // Aligned boxes per code, with code and payload churned mid scan
        for (int i = 0; i < 4; i++) begin
            run_box(codes[i], rand_range(1, 6), rand_range(1, 6), 1'b1, 1'b1, 1'b0);
        end
        // Unaligned boxes overshoot the maximum
        for (int i = 0; i < 4; i++) begin
            run_box(codes[i], rand_range(2, 6), rand_range(2, 6), 1'b0, 1'b0, 1'b0);
        end
        // Zero-size box
        run_box(4'b1000, 1, 1, 1'b1, 1'b0, 1'b0);
        // Back to back with tri_valid held high
        for (int i = 0; i < 12; i++) begin
            run_box(codes[i % 4], rand_range(1, 6), rand_range(1, 6), i[0], 1'b0, 1'b1);
        end
        tri_valid = 1'b0;
        repeat (4) @(posedge clk);
        if (exp_x.size() != 0) begin
            errors++;
            $display("%0d expected samples never appeared", exp_x.size());
        end
        $display("Checks %0d, errors %0d, boxes %0d", checks, errors, boxes);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/sample_iterator_props.sv ====
// Bound into the walker, every property is masked while reset is high
`timescale 1ns/100ps

module sample_iterator_props (
    input logic                    clk,
    input logic                    rst,
    input iter_ctrl_pkg::iter_state_t state,
    input logic                    tri_valid,
    input logic                    at_end_box,
    input logic                    sample_valid,
    input raster_geom_pkg::coord_t sample [1:0],
    input raster_geom_pkg::coord_t box [1:0][1:0]
);
    import iter_ctrl_pkg::*;

    // Accepting edge moves the FSM into the walk
    accept_to_test: assert property (
        @(posedge clk) disable iff (rst)
        (state == WAIT_STATE && tri_valid) |=> (state == TEST_STATE)
    ) else $error("FSM missed the testing state after an accepted triangle");

    // Last sample returns the FSM to waiting
    end_to_wait: assert property (
        @(posedge clk) disable iff (rst)
        (state == TEST_STATE && at_end_box) |=> (state == WAIT_STATE)
    ) else $error("FSM stayed in the walk after the last sample of a box");

    // A valid sample never lies below or left of the stored box
    sample_above_min: assert property (
        @(posedge clk) disable iff (rst)
        sample_valid |-> (sample[0] >= box[0][0] && sample[1] >= box[0][1])
    ) else $error("Valid sample lies outside the lower-left corner of the box");

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Free-running clock from time zero, reset released 1 ns after the last reset edge
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);
    // Clock starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset drops at the same offset as any other driven input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// ==== hdl/sample_test_iterator.sv ====
// No handshake downstream, upstream must hold its inputs while halt_n is low and RADIX must be at least 3
`timescale 1ns/100ps

module sample_test_iterator #(
    parameter int unsigned RADIX = 10
) (
    input  logic                      clk,
    input  logic                      rst,
    input  raster_geom_pkg::coord_t   tri_in [raster_geom_pkg::VERTS-1:0][raster_geom_pkg::AXIS-1:0],
    input  raster_geom_pkg::color_t   color_in [raster_geom_pkg::COLORS-1:0],
    input  raster_geom_pkg::coord_t   box_in [1:0][1:0],
    input  logic                      tri_valid,
    input  iter_ctrl_pkg::msaa_code_t msaa_code,
    output raster_geom_pkg::coord_t   tri_out [raster_geom_pkg::VERTS-1:0][raster_geom_pkg::AXIS-1:0],
    output raster_geom_pkg::color_t   color_out [raster_geom_pkg::COLORS-1:0],
    output raster_geom_pkg::coord_t   sample [1:0],
    output logic                      sample_valid,
    output logic                      halt_n
);
    import iter_ctrl_pkg::*;

    // Accepting-edge pulse from the walker
    logic start;

    // Step for the box in progress
    step_t step;

    // Step register
    // Owns the fixed-point position of the MSAA code
    sample_step_config #(
        .RADIX (RADIX)
    ) u_step_cfg (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .msaa_code (msaa_code),
        .step      (step)
    );

    // Box walker
    // All outputs to the pins are registered here
    bbox_sample_iterator u_iter (
        .clk          (clk),
        .rst          (rst),
        .tri_in       (tri_in),
        .color_in     (color_in),
        .box_in       (box_in),
        .tri_valid    (tri_valid),
        .step         (step),
        .start        (start),
        .tri_out      (tri_out),
        .color_out    (color_out),
        .sample       (sample),
        .sample_valid (sample_valid),
        .halt_n       (halt_n)
    );

endmodule

// ==== hdl/bbox_sample_iterator.sv ====
// Walks the box bottom to top, left to right, one sample per cycle with no downstream stall
`timescale 1ns/100ps

module bbox_sample_iterator (
    input  logic                    clk,
    input  logic                    rst,
    input  raster_geom_pkg::coord_t tri_in [raster_geom_pkg::VERTS-1:0][raster_geom_pkg::AXIS-1:0],
    input  raster_geom_pkg::color_t color_in [raster_geom_pkg::COLORS-1:0],
    input  raster_geom_pkg::coord_t box_in [1:0][1:0],
    input  logic                    tri_valid,
    input  iter_ctrl_pkg::step_t    step,
    output logic                    start,
    output raster_geom_pkg::coord_t tri_out [raster_geom_pkg::VERTS-1:0][raster_geom_pkg::AXIS-1:0],
    output raster_geom_pkg::color_t color_out [raster_geom_pkg::COLORS-1:0],
    output raster_geom_pkg::coord_t sample [1:0],
    output logic                    sample_valid,
    output logic                    halt_n
);
    import raster_geom_pkg::*;
    import iter_ctrl_pkg::*;

    // FSM state
    iter_state_t state;
    iter_state_t next_state;

    // Box being walked
    // Corner 0 is the lower left, corner 1 the upper right
    coord_t box [1:0][1:0];
    coord_t next_box [1:0][1:0];

    // Next values of the registered outputs
    coord_t next_sample [1:0];
    coord_t next_tri [VERTS-1:0][AXIS-1:0];
    color_t next_color [COLORS-1:0];
    logic   next_valid;
    logic   next_halt_n;

    // Candidate samples
    // One step to the right, or back to min x one row up
    coord_t rt_sample [1:0];
    coord_t up_sample [1:0];

    // Position of the current sample in the box
    logic at_right_edge;
    logic at_top_edge;
    logic at_end_box;

    // Accepting edge
    // Combinational so the step register loads on the same edge
    assign start = (state == WAIT_STATE) && tri_valid;

    // Right step keeps the row
    assign rt_sample[0] = sample[0] + step;
    assign rt_sample[1] = sample[1];

    // Row-up step returns to the left edge
    assign up_sample[0] = box[0][0];
    assign up_sample[1] = sample[1] + step;

    // Edge tests against the stored maximum
    // At or beyond, so an unaligned box overshoots by under one step
    assign at_right_edge = (sample[0] >= box[1][0]);
    assign at_top_edge   = (sample[1] >= box[1][1]);

    // Last sample of the box
    assign at_end_box = at_right_edge && at_top_edge;

    // Next-state and next-output logic
    always_comb begin
        // Hold everything unless a branch says otherwise
        next_state  = state;
        next_box    = box;
        next_sample = sample;
        next_tri    = tri_out;
        next_color  = color_out;
        next_valid  = sample_valid;
        next_halt_n = halt_n;

        case (state)
            WAIT_STATE: begin
                // Idle outputs track the inputs one cycle late
                next_box   = box_in;
                next_tri   = tri_in;
                next_color = color_in;

                // First sample is the lower-left corner
                next_sample[0] = box_in[0][0];
                next_sample[1] = box_in[0][1];

                // Valid triangle starts the walk and halts upstream
                next_valid  = tri_valid;
                next_halt_n = !tri_valid;
                if (tri_valid) begin
                    next_state = TEST_STATE;
                end
            end

            TEST_STATE: begin
                if (at_end_box) begin
                    // Box done
                    next_state  = WAIT_STATE;
                    next_valid  = 1'b0;
                    next_halt_n = 1'b1;

                    // Park on the lower-left corner of the finished box
                    next_sample[0] = box[0][0];
                    next_sample[1] = box[0][1];
                end else if (at_right_edge) begin
                    // End of a row
                    next_sample = up_sample;
                end else begin
                    next_sample = rt_sample;
                end
                // Triangle, color and box hold for the whole walk
            end
        endcase
    end

    // Control registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= WAIT_STATE;
            sample_valid <= 1'b0;
            halt_n       <= 1'b1;
        end else begin
            state        <= next_state;
            sample_valid <= next_valid;
            halt_n       <= next_halt_n;
        end
    end

    // Box and sample registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            box    <= '{default: '0};
            sample <= '{default: '0};
        end else begin
            box    <= next_box;
            sample <= next_sample;
        end
    end

    // Triangle and color payload
    always_ff @(posedge clk) begin
        tri_out   <= next_tri;
        color_out <= next_color;
    end

    // halt_n is the inverse of sample_valid on every cycle
    // Both come from the same branch of the next-state logic

endmodule

// ==== hdl/sample_step_config.sv ====
// RADIX must be at least 3 and the step only changes on start so a box always walks with one step
`timescale 1ns/100ps

module sample_step_config #(
    parameter int unsigned RADIX = 10
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  iter_ctrl_pkg::msaa_code_t msaa_code,
    output iter_ctrl_pkg::step_t      step
);
    import iter_ctrl_pkg::*;

    // One sample per pixel, the value held out of reset
    localparam msaa_code_t CODE_1X = 4'b1000;

    // Bit 3 of the code maps onto bit RADIX
    localparam int unsigned SHIFT = RADIX - 3;

    // Code placed at the fixed-point position
    step_t code_step;

    // Zero-extend the code, then move it under the binary point
    // 0100 gives half a pixel, 0010 a quarter, 0001 an eighth
    assign code_step = step_t'(msaa_code) << SHIFT;

    // Step register
    // Loads on the accepting edge only
    // A code change mid box waits for the next start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Whole-pixel step until the first triangle
            step <= step_t'(CODE_1X) << SHIFT;
        end else if (start) begin
            step <= code_step;
        end
    end

    // The walker sees the new step one edge after start
    // which is the first edge that can move the sample

endmodule

// ==== hdl/iter_ctrl_pkg.sv ====
// Only the four one-hot MSAA codes are defined and a zero code gives a zero step that never ends a box
package iter_ctrl_pkg;

    // Walk FSM states
    typedef enum logic {
        WAIT_STATE = 1'b0,
        TEST_STATE = 1'b1
    } iter_state_t;

    // One-hot subsample code
    // 1000 is 1x, 0100 is 4x, 0010 is 16x, 0001 is 64x
    typedef logic [3:0] msaa_code_t;

    // Signed sample step in coordinate units
    // Same width as a coordinate so it adds without extension
    typedef logic signed [raster_geom_pkg::SIGFIG-1:0] step_t;

    // Step is the code shifted left by RADIX-3
    // so 1000 lands on bit RADIX, one whole pixel

endpackage

// ==== hdl/raster_geom_pkg.sv ====
// Coordinates are two's complement fixed point and the fraction width is chosen by the design's RADIX
package raster_geom_pkg;

    // Bits in one coordinate or one color channel
    localparam int SIGFIG = 24;

    // Vertices per triangle
    localparam int VERTS = 3;

    // Axes per vertex, x then y then z
    localparam int AXIS = 3;

    // Color channels per triangle
    localparam int COLORS = 3;

    // Signed fixed-point coordinate
    // Integer part in the upper bits, fraction in the low RADIX bits
    typedef logic signed [SIGFIG-1:0] coord_t;

    // Unsigned color channel
    typedef logic [SIGFIG-1:0] color_t;

    // Vertex indexing is [vertex][axis]
    // Box indexing is [corner][axis], corner 0 is the minimum
    // A sample is two coordinates, x at index 0 and y at index 1

endpackage
